// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_rvc_expander
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FLIST)) rvc_defs.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q '^STATUS: PASS$$'

clean:
	rm -rf $(OBJ_DIR)

// File: flist.f
+incdir+.
rvc_pkg.sv
rvc_classify_stage.sv
rvc_expand_stage.sv
rvc_issue_stage.sv
rvc_expander.sv
tb_rvc_expander.sv

// File: rvc_classify_stage.sv
// RVC classify stage

`timescale 1ns/100ps
`default_nettype none

`include "rvc_defs.svh"

module rvc_classify_stage (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 valid_i,
  input  logic [`RVC_ILEN-1:0] instr_i,
  output logic                 valid_o,
  output rvc_pkg::rvc_class_t  class_o
);

  rvc_pkg::rvc_op_e    op_d;
  logic                rd_zero;
  logic                rs2_zero;
  logic                valid_q;
  rvc_pkg::rvc_class_t class_q;

  assign rd_zero  = (instr_i[11:7] == 5'd0);
  assign rs2_zero = (instr_i[6:2] == 5'd0);

  // ----------------------------------------------------------------------
  // quadrant and funct3 decode
  // ----------------------------------------------------------------------
  always_comb begin
    op_d = rvc_pkg::op_reserved;
    unique case (instr_i[1:0])
      2'b00: begin
        unique case (instr_i[15:13])
          3'b000: op_d = rvc_pkg::op_c_addi4spn;
          3'b010: op_d = rvc_pkg::op_c_lw;
          3'b110: op_d = rvc_pkg::op_c_sw;
          // fld, flw, zcb loads and stores, fsd, fsw
          default: op_d = rvc_pkg::op_reserved;
        endcase
      end

      2'b01: begin
        unique case (instr_i[15:13])
          3'b000: op_d = rvc_pkg::op_c_addi;
          3'b001: op_d = rvc_pkg::op_c_jal;
          3'b010: op_d = rvc_pkg::op_c_li;
          3'b011: begin
            // rd of sp selects the stack pointer adjust
            if (instr_i[11:7] == `RVC_REG_SP) begin
              op_d = rvc_pkg::op_c_addi16sp;
            end else begin
              op_d = rvc_pkg::op_c_lui;
            end
          end
          3'b100: begin
            // misc-alu group
            unique case (instr_i[11:10])
              2'b00: op_d = rvc_pkg::op_c_srli;
              2'b01: op_d = rvc_pkg::op_c_srai;
              2'b10: op_d = rvc_pkg::op_c_andi;
              default: begin
                unique case ({instr_i[12], instr_i[6:5]})
                  3'b000: op_d = rvc_pkg::op_c_sub;
                  3'b001: op_d = rvc_pkg::op_c_xor;
                  3'b010: op_d = rvc_pkg::op_c_or;
                  3'b011: op_d = rvc_pkg::op_c_and;
                  // subw, addw, zcb mul and unary ops
                  default: op_d = rvc_pkg::op_reserved;
                endcase
              end
            endcase
          end
          3'b101: op_d = rvc_pkg::op_c_j;
          3'b110: op_d = rvc_pkg::op_c_beqz;
          default: op_d = rvc_pkg::op_c_bnez;
        endcase
      end

      2'b10: begin
        unique case (instr_i[15:13])
          3'b000: op_d = rvc_pkg::op_c_slli;
          3'b010: op_d = rvc_pkg::op_c_lwsp;
          3'b100: begin
            // jr/mv/add group, split by bit 12 and a zero rs2
            if (!instr_i[12]) begin
              op_d = rs2_zero ? rvc_pkg::op_c_jr : rvc_pkg::op_c_mv;
            end else if (!rs2_zero) begin
              op_d = rvc_pkg::op_c_add;
            end else begin
              op_d = rd_zero ? rvc_pkg::op_c_ebreak : rvc_pkg::op_c_jalr;
            end
          end
          3'b110: op_d = rvc_pkg::op_c_swsp;
          // fldsp, flwsp, fsdsp and zcmp, fswsp
          default: op_d = rvc_pkg::op_reserved;
        endcase
      end

      // low bits 11 mark a full-width word
      default: op_d = rvc_pkg::op_none;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      class_q.instr <= instr_i;
      class_q.op    <= op_d;
    end
  end

  assign valid_o = valid_q;
  assign class_o = class_q;

endmodule

`default_nettype wire

// File: rvc_defs.svh
// RVC expander definitions

`ifndef RVC_DEFS_SVH
`define RVC_DEFS_SVH

// instruction widths
`define RVC_ILEN 32
`define RVC_CLEN 16

// credit depths, the input side matches the issue queue depth
`define RVC_IN_CREDITS  4
`define RVC_OUT_CREDITS 4
`define RVC_CREDIT_W    3

// fixed register numbers
`define RVC_REG_SP 5'd2
`define RVC_REG_RA 5'd1

// upper bits that turn a 3-bit prime register into x8..x15
`define RVC_REG_PRIME 2'b01

// ebreak has no operands
`define RVC_EBREAK 32'h0010_0073

`endif

// File: rvc_expand_stage.sv
// RVC expand stage

`timescale 1ns/100ps
`default_nettype none

`include "rvc_defs.svh"

module rvc_expand_stage (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 valid_i,
  input  rvc_pkg::rvc_class_t  class_i,
  output logic                 valid_o,
  output rvc_pkg::rvc_result_t result_o
);

  logic [`RVC_CLEN-1:0] c;
  logic [4:0]           rd;
  logic [4:0]           rs2;
  logic [4:0]           rs1p;
  logic [4:0]           rs2p;
  logic [19:0]          jimm;
  logic [`RVC_ILEN-1:0] instr_d;
  logic                 illegal_d;
  rvc_pkg::rvc_result_t result_d;
  logic                 valid_q;
  rvc_pkg::rvc_result_t result_q;

  // ----------------------------------------------------------------------
  // operand fields shared by several formats
  // ----------------------------------------------------------------------
  assign c    = class_i.instr[`RVC_CLEN-1:0];
  assign rd   = c[11:7];
  assign rs2  = c[6:2];
  assign rs1p = {`RVC_REG_PRIME, c[9:7]};
  assign rs2p = {`RVC_REG_PRIME, c[4:2]};

  // CJ offset already in jal order
  assign jimm = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], {9{c[12]}}};

  always_comb begin
    instr_d   = class_i.instr;
    illegal_d = 1'b0;
    unique case (class_i.op)
      // CIW
      rvc_pkg::op_c_addi4spn: begin
        instr_d = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00, `RVC_REG_SP, 3'b000,
                   rs2p, rvc_pkg::opc_op_imm};
        illegal_d = (c[12:5] == 8'd0);
      end
      // CL and CS word access
      rvc_pkg::op_c_lw: begin
        instr_d = {5'd0, c[5], c[12:10], c[6], 2'b00, rs1p, 3'b010, rs2p,
                   rvc_pkg::opc_load};
      end
      rvc_pkg::op_c_sw: begin
        instr_d = {5'd0, c[5], c[12], rs2p, rs1p, 3'b010, c[11:10], c[6], 2'b00,
                   rvc_pkg::opc_store};
      end

      // CI immediates, nop falls out of addi with rd x0
      rvc_pkg::op_c_addi: begin
        instr_d = {{7{c[12]}}, c[6:2], rd, 3'b000, rd, rvc_pkg::opc_op_imm};
      end
      rvc_pkg::op_c_li: begin
        instr_d = {{7{c[12]}}, c[6:2], 5'd0, 3'b000, rd, rvc_pkg::opc_op_imm};
      end
      rvc_pkg::op_c_lui: begin
        instr_d   = {{15{c[12]}}, c[6:2], rd, rvc_pkg::opc_lui};
        illegal_d = ({c[12], c[6:2]} == 6'd0);
      end
      rvc_pkg::op_c_addi16sp: begin
        instr_d = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0000, `RVC_REG_SP, 3'b000,
                   `RVC_REG_SP, rvc_pkg::opc_op_imm};
        illegal_d = ({c[12], c[6:2]} == 6'd0);
      end

      // CB shifts and andi on a prime register
      rvc_pkg::op_c_srli,
      rvc_pkg::op_c_srai: begin
        instr_d = {1'b0, c[10], 4'b0000, c[12], c[6:2], rs1p, 3'b101, rs1p,
                   rvc_pkg::opc_op_imm};
      end
      rvc_pkg::op_c_andi: begin
        instr_d = {{7{c[12]}}, c[6:2], rs1p, 3'b111, rs1p, rvc_pkg::opc_op_imm};
      end

      // CA register ops
      rvc_pkg::op_c_sub: begin
        instr_d = {7'b0100000, rs2p, rs1p, 3'b000, rs1p, rvc_pkg::opc_op};
      end
      rvc_pkg::op_c_xor: begin
        instr_d = {7'd0, rs2p, rs1p, 3'b100, rs1p, rvc_pkg::opc_op};
      end
      rvc_pkg::op_c_or: begin
        instr_d = {7'd0, rs2p, rs1p, 3'b110, rs1p, rvc_pkg::opc_op};
      end
      rvc_pkg::op_c_and: begin
        instr_d = {7'd0, rs2p, rs1p, 3'b111, rs1p, rvc_pkg::opc_op};
      end

      // CJ jumps, jal links through ra
      rvc_pkg::op_c_jal: begin
        instr_d = {jimm, `RVC_REG_RA, rvc_pkg::opc_jal};
      end
      rvc_pkg::op_c_j: begin
        instr_d = {jimm, 5'd0, rvc_pkg::opc_jal};
      end

      // CB branches against x0, funct3 bit 0 comes from c[13]
      rvc_pkg::op_c_beqz,
      rvc_pkg::op_c_bnez: begin
        instr_d = {{4{c[12]}}, c[6:5], c[2], 5'd0, rs1p, 2'b00, c[13], c[11:10], c[4:3],
                   c[12], rvc_pkg::opc_branch};
      end

      // quadrant 2
      rvc_pkg::op_c_slli: begin
        instr_d = {6'd0, c[12], c[6:2], rd, 3'b001, rd, rvc_pkg::opc_op_imm};
      end
      rvc_pkg::op_c_lwsp: begin
        instr_d = {4'd0, c[3:2], c[12], c[6:4], 2'b00, `RVC_REG_SP, 3'b010, rd,
                   rvc_pkg::opc_load};
        illegal_d = (rd == 5'd0);
      end
      rvc_pkg::op_c_swsp: begin
        instr_d = {4'd0, c[8:7], c[12], rs2, `RVC_REG_SP, 3'b010, c[11:9], 2'b00,
                   rvc_pkg::opc_store};
      end
      // CR forms
      rvc_pkg::op_c_jr: begin
        instr_d   = {12'd0, rd, 3'b000, 5'd0, rvc_pkg::opc_jalr};
        illegal_d = (rd == 5'd0);
      end
      rvc_pkg::op_c_jalr: begin
        instr_d = {12'd0, rd, 3'b000, `RVC_REG_RA, rvc_pkg::opc_jalr};
      end
      rvc_pkg::op_c_mv: begin
        instr_d = {7'd0, rs2, 5'd0, 3'b000, rd, rvc_pkg::opc_op};
      end
      rvc_pkg::op_c_add: begin
        instr_d = {7'd0, rs2, rd, 3'b000, rd, rvc_pkg::opc_op};
      end
      rvc_pkg::op_c_ebreak: begin
        instr_d = `RVC_EBREAK;
      end

      rvc_pkg::op_reserved: begin
        illegal_d = 1'b1;
      end
      // full-width word passes as is
      default: begin
        instr_d = class_i.instr;
      end
    endcase
  end

  // an illegal word leaves with its raw bits
  assign result_d.instr      = illegal_d ? class_i.instr : instr_d;
  assign result_d.illegal    = illegal_d;
  assign result_d.compressed = (class_i.op != rvc_pkg::op_none);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      result_q <= result_d;
    end
  end

  assign valid_o  = valid_q;
  assign result_o = result_q;

endmodule

`default_nettype wire

// File: rvc_expander.sv
// RVC expander top

`timescale 1ns/100ps
`default_nettype none

`include "rvc_defs.svh"

module rvc_expander (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 in_valid_i,
  input  logic [`RVC_ILEN-1:0] instr_i,
  output logic                 in_credit_o,
  output logic                 out_valid_o,
  output rvc_pkg::rvc_result_t out_result_o,
  input  logic                 out_credit_i
);

  logic                 class_valid;
  rvc_pkg::rvc_class_t  class_word;
  logic                 expand_valid;
  rvc_pkg::rvc_result_t expand_result;

  rvc_classify_stage i_rvc_classify_stage (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (in_valid_i),
    .instr_i (instr_i),
    .valid_o (class_valid),
    .class_o (class_word)
  );

  rvc_expand_stage i_rvc_expand_stage (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .valid_i  (class_valid),
    .class_i  (class_word),
    .valid_o  (expand_valid),
    .result_o (expand_result)
  );

  rvc_issue_stage i_rvc_issue_stage (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .valid_i      (expand_valid),
    .result_i     (expand_result),
    .out_credit_i (out_credit_i),
    .out_valid_o  (out_valid_o),
    .out_result_o (out_result_o),
    .in_credit_o  (in_credit_o)
  );

endmodule

`default_nettype wire

// File: rvc_issue_stage.sv
// RVC issue queue

`timescale 1ns/100ps
`default_nettype none

`include "rvc_defs.svh"

module rvc_issue_stage (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 valid_i,
  input  rvc_pkg::rvc_result_t result_i,
  input  logic                 out_credit_i,
  output logic                 out_valid_o,
  output rvc_pkg::rvc_result_t out_result_o,
  output logic                 in_credit_o
);

  localparam int unsigned DEPTH = `RVC_IN_CREDITS;
  localparam int unsigned PTR_W = $clog2(`RVC_IN_CREDITS);

  rvc_pkg::rvc_result_t     mem_q [DEPTH];
  logic [PTR_W-1:0]         wr_ptr_q;
  logic [PTR_W-1:0]         rd_ptr_q;
  logic [`RVC_CREDIT_W-1:0] fill_q;
  logic [`RVC_CREDIT_W-1:0] credit_q;
  logic                     queue_empty;
  logic                     bypass;
  logic                     push;
  logic                     pop;
  logic                     in_credit_q;

  assign queue_empty = (fill_q == '0);

  // an empty queue hands the incoming entry straight out
  assign out_valid_o  = (!queue_empty || valid_i) && (credit_q != '0);
  assign out_result_o = queue_empty ? result_i : mem_q[rd_ptr_q];
  assign bypass       = out_valid_o && queue_empty;
  assign push         = valid_i && !bypass;
  assign pop          = out_valid_o && !queue_empty;

  // ----------------------------------------------------------------------
  // queue pointers and fill level
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      fill_q <= fill_q + push - pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= result_i;
    end
  end

  // ----------------------------------------------------------------------
  // output credits and input credit return
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credit_q    <= `RVC_CREDIT_W'(`RVC_OUT_CREDITS);
      in_credit_q <= 1'b0;
    end else begin
      credit_q    <= credit_q - out_valid_o + out_credit_i;
      // every entry that leaves frees one upstream slot
      in_credit_q <= out_valid_o;
    end
  end

  assign in_credit_o = in_credit_q;

  // upstream credits cover the stages and the queue, so a full queue sees no push
  assert property (@(posedge clk_i) disable iff (reset_i) push |-> (fill_q < DEPTH))
    else $error("issue queue push while full");

  // downstream never returns more credits than were spent
  assert property (@(posedge clk_i) disable iff (reset_i)
    (out_credit_i && !out_valid_o) |-> (credit_q < `RVC_OUT_CREDITS))
    else $error("output credit count overflow");

endmodule

`default_nettype wire

// File: rvc_pkg.sv
// RVC expander types

`default_nettype none

`include "rvc_defs.svh"

package rvc_pkg;

  // ----------------------------------------------------------------------
  // base major opcodes
  // ----------------------------------------------------------------------
  typedef enum logic [6:0] {
    opc_load   = 7'b0000011,
    opc_op_imm = 7'b0010011,
    opc_store  = 7'b0100011,
    opc_op     = 7'b0110011,
    opc_lui    = 7'b0110111,
    opc_branch = 7'b1100011,
    opc_jalr   = 7'b1100111,
    opc_jal    = 7'b1101111,
    opc_system = 7'b1110011
  } rv_opcode_e;

  // ----------------------------------------------------------------------
  // compressed operations
  // ----------------------------------------------------------------------
  typedef enum logic [4:0] {
    op_none,
    op_reserved,
    // quadrant 0
    op_c_addi4spn,
    op_c_lw,
    op_c_sw,
    // quadrant 1
    op_c_addi,
    op_c_jal,
    op_c_li,
    op_c_lui,
    op_c_addi16sp,
    op_c_srli,
    op_c_srai,
    op_c_andi,
    op_c_sub,
    op_c_xor,
    op_c_or,
    op_c_and,
    op_c_j,
    op_c_beqz,
    op_c_bnez,
    // quadrant 2
    op_c_slli,
    op_c_lwsp,
    op_c_jr,
    op_c_mv,
    op_c_ebreak,
    op_c_jalr,
    op_c_add,
    op_c_swsp
  } rvc_op_e;

  // classify to expand
  typedef struct packed {
    logic [`RVC_ILEN-1:0] instr;
    rvc_op_e              op;
  } rvc_class_t;

  // expand to queue and out
  typedef struct packed {
    logic [`RVC_ILEN-1:0] instr;
    logic                 illegal;
    logic                 compressed;
  } rvc_result_t;

endpackage

`default_nettype wire

// File: tb_rvc_expander.sv
// RVC expander testbench

`timescale 1ns/100ps
`default_nettype none

`include "rvc_defs.svh"

module tb_rvc_expander;

  localparam int TOTAL_WORDS = 40 + 208 + 84 + 120;
  localparam int CYCLE_LIMIT = TOTAL_WORDS * 20 + 1000;
  localparam int MAX_WINDOW  = `RVC_OUT_CREDITS + `RVC_IN_CREDITS;

  logic                 clk_i;
  logic                 reset_i;
  logic                 in_valid_i;
  logic [`RVC_ILEN-1:0] instr_i;
  logic                 in_credit_o;
  logic                 out_valid_o;
  rvc_pkg::rvc_result_t out_result_o;
  logic                 out_credit_i;

  logic [31:0]          lfsr_q = 32'hd20b7698;
  rvc_pkg::rvc_result_t exp_q[$];
  logic [31:0]          src_q[$];
  int error_count = 0;
  int checks_done = 0;
  int sent_cnt = 0;
  int received = 0;
  int granted = 0;
  int returned = 0;
  int up_credits = `RVC_IN_CREDITS;
  int window = 0;
  int stall_left = 0;
  int cycles = 0;
  logic stall_en = 1'b0;
  logic grant_q = 1'b0;

  rvc_expander i_rvc_expander (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .in_valid_i   (in_valid_i),
    .instr_i      (instr_i),
    .in_credit_o  (in_credit_o),
    .out_valid_o  (out_valid_o),
    .out_result_o (out_result_o),
    .out_credit_i (out_credit_i)
  );

  always #2 clk_i = ~clk_i;

  // ----------------------------------------------------------------------
  // random bits with one lfsr step per bit
  // ----------------------------------------------------------------------
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  // base formats
  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'd2, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], 5'd0, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  // ----------------------------------------------------------------------
  // reference expansion from the compressed format rules
  // ----------------------------------------------------------------------
  function automatic rvc_pkg::rvc_result_t ref_expand(input logic [31:0] w);
    rvc_pkg::rvc_result_t res;
    logic [15:0] c;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [4:0]  rdp;
    logic [4:0]  rs2p;
    logic [11:0] ci_imm;
    logic [20:0] jimm;
    logic [12:0] bimm;
    logic [31:0] o;
    logic        bad;
    c      = w[15:0];
    rd     = c[11:7];
    rs2    = c[6:2];
    rdp    = {2'b01, c[9:7]};
    rs2p   = {2'b01, c[4:2]};
    ci_imm = {{6{c[12]}}, c[12], c[6:2]};
    jimm   = {{10{c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
    bimm   = {{5{c[12]}}, c[6:5], c[2], c[11:10], c[4:3], 1'b0};
    o      = w;
    bad    = 1'b0;
    case ({c[1:0], c[15:13]})
      5'b00_000: begin
        o   = enc_i({2'b0, c[10:7], c[12:11], c[5], c[6], 2'b0}, 5'd2, 3'd0, rs2p, 7'h13);
        bad = (c[12:5] == 8'd0);
      end
      5'b00_010: o = enc_i({5'b0, c[5], c[12:10], c[6], 2'b0}, rdp, 3'd2, rs2p, 7'h03);
      5'b00_110: o = enc_s({5'b0, c[5], c[12:10], c[6], 2'b0}, rs2p, rdp);
      5'b01_000: o = enc_i(ci_imm, rd, 3'd0, rd, 7'h13);
      5'b01_001: o = enc_j(jimm, 5'd1);
      5'b01_010: o = enc_i(ci_imm, 5'd0, 3'd0, rd, 7'h13);
      5'b01_011: begin
        if (rd == 5'd2) begin
          o = enc_i({{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0}, 5'd2, 3'd0, 5'd2, 7'h13);
        end else begin
          o = {{15{c[12]}}, c[6:2], rd, 7'h37};
        end
        bad = ({c[12], c[6:2]} == 6'd0);
      end
      5'b01_100: begin
        case (c[11:10])
          2'b00: o = enc_i({6'b0, c[12], c[6:2]}, rdp, 3'd5, rdp, 7'h13);
          2'b01: o = enc_i({6'b010000, c[12], c[6:2]}, rdp, 3'd5, rdp, 7'h13);
          2'b10: o = enc_i(ci_imm, rdp, 3'd7, rdp, 7'h13);
          default: begin
            if (c[12]) begin
              bad = 1'b1;
            end else begin
              case (c[6:5])
                2'b00: o = enc_r(7'h20, rs2p, rdp, 3'd0, rdp);
                2'b01: o = enc_r(7'h00, rs2p, rdp, 3'd4, rdp);
                2'b10: o = enc_r(7'h00, rs2p, rdp, 3'd6, rdp);
                default: o = enc_r(7'h00, rs2p, rdp, 3'd7, rdp);
              endcase
            end
          end
        endcase
      end
      5'b01_101: o = enc_j(jimm, 5'd0);
      5'b01_110: o = enc_b(bimm, rdp, 3'd0);
      5'b01_111: o = enc_b(bimm, rdp, 3'd1);
      5'b10_000: o = enc_i({6'b0, c[12], c[6:2]}, rd, 3'd1, rd, 7'h13);
      5'b10_010: begin
        o   = enc_i({4'b0, c[3:2], c[12], c[6:4], 2'b0}, 5'd2, 3'd2, rd, 7'h03);
        bad = (rd == 5'd0);
      end
      5'b10_100: begin
        if (!c[12] && rs2 == 5'd0) begin
          o   = enc_i(12'd0, rd, 3'd0, 5'd0, 7'h67);
          bad = (rd == 5'd0);
        end else if (!c[12]) begin
          o = enc_r(7'h00, rs2, 5'd0, 3'd0, rd);
        end else if (rs2 != 5'd0) begin
          o = enc_r(7'h00, rs2, rd, 3'd0, rd);
        end else if (rd == 5'd0) begin
          o = 32'h0010_0073;
        end else begin
          o = enc_i(12'd0, rd, 3'd0, 5'd1, 7'h67);
        end
      end
      5'b10_110: o = enc_s({4'b0, c[8:7], c[12:9], 2'b0}, rs2, 5'd2);
      default: bad = (c[1:0] != 2'b11);
    endcase
    res.instr      = bad ? w : o;
    res.illegal    = bad;
    res.compressed = (c[1:0] != 2'b11);
    return res;
  endfunction

  // one legal word for each of the 26 kept operations
  function automatic logic [15:0] legal_word(input int idx);
    logic [15:0] r;
    r = rand_bits(16);
    case (idx)
      0: begin
        r[15:13] = 3'd0;
        r[1:0]   = 2'b00;
        if (r[12:5] == 8'd0) r[5] = 1'b1;
      end
      1: begin
        r[15:13] = 3'd2;
        r[1:0]   = 2'b00;
      end
      2: begin
        r[15:13] = 3'd6;
        r[1:0]   = 2'b00;
      end
      3, 4, 5: begin
        r[15:13] = 3'(idx - 3);
        r[1:0]   = 2'b01;
      end
      6, 7: begin
        r[15:13] = 3'd3;
        r[1:0]   = 2'b01;
        if (idx == 7) r[11:7] = 5'd2;
        else if (r[11:7] == 5'd2) r[11:7] = 5'd3;
        if ({r[12], r[6:2]} == 6'd0) r[2] = 1'b1;
      end
      8, 9, 10: begin
        r[15:13] = 3'd4;
        r[1:0]   = 2'b01;
        r[11:10] = 2'(idx - 8);
      end
      11, 12, 13, 14: begin
        r[15:13] = 3'd4;
        r[1:0]   = 2'b01;
        r[12:10] = 3'b011;
        r[6:5]   = 2'(idx - 11);
      end
      15, 16, 17: begin
        r[15:13] = 3'(idx - 10);
        r[1:0]   = 2'b01;
      end
      18: begin
        r[15:13] = 3'd0;
        r[1:0]   = 2'b10;
      end
      19: begin
        r[15:13] = 3'd2;
        r[1:0]   = 2'b10;
        if (r[11:7] == 5'd0) r[7] = 1'b1;
      end
      25: begin
        r[15:13] = 3'd6;
        r[1:0]   = 2'b10;
      end
      default: begin
        // jr, mv, ebreak, jalr, add
        r[15:13] = 3'd4;
        r[1:0]   = 2'b10;
        r[12]    = (idx >= 22);
        if (idx == 20 || idx == 22 || idx == 23) r[6:2] = 5'd0;
        else if (r[6:2] == 5'd0) r[2] = 1'b1;
        if (idx == 22) r[11:7] = 5'd0;
        else if ((idx == 20 || idx == 23) && r[11:7] == 5'd0) r[7] = 1'b1;
      end
    endcase
    return r;
  endfunction

  // reserved values first and then the dropped rv64, float and zcb encodings
  function automatic logic [15:0] illegal_word(input int idx);
    logic [15:0] r;
    r = rand_bits(16);
    case (idx)
      0: begin
        r[15:13] = 3'd0;
        r[1:0]   = 2'b00;
        r[12:5]  = 8'd0;
      end
      1, 2: begin
        r[15:13] = 3'd3;
        r[1:0]   = 2'b01;
        r[12]    = 1'b0;
        r[6:2]   = 5'd0;
        if (idx == 2) r[11:7] = 5'd2;
        else if (r[11:7] == 5'd2) r[11:7] = 5'd3;
      end
      3: begin
        r[15:13] = 3'd2;
        r[1:0]   = 2'b10;
        r[11:7]  = 5'd0;
      end
      4: begin
        r[15:13] = 3'd4;
        r[1:0]   = 2'b10;
        r[12:2]  = 11'd0;
      end
      5: begin
        r[15:13] = 3'd1;
        r[1:0]   = 2'b00;
      end
      6: begin
        r[15:13] = 3'd3;
        r[1:0]   = 2'b00;
      end
      7: begin
        r[15:13] = 3'd4;
        r[1:0]   = 2'b00;
      end
      8: begin
        r[15:13] = 3'd5;
        r[1:0]   = 2'b00;
      end
      9: begin
        r[15:13] = 3'd7;
        r[1:0]   = 2'b00;
      end
      10: begin
        r[15:13] = 3'd4;
        r[1:0]   = 2'b01;
        r[12:10] = 3'b111;
      end
      default: begin
        r[15:13] = 3'((idx - 11) * 2 + 1);
        r[1:0]   = 2'b10;
      end
    endcase
    return r;
  endfunction

  function automatic logic [31:0] make_word(input int kind, input int i);
    case (kind)
      0: return rand_bits(32) | 32'h3;
      1: return {rand_bits(16), legal_word(i % 26)};
      2: return {rand_bits(16), illegal_word(i % 15)};
      default: return {rand_bits(16), legal_word(rand_bits(5) % 26)};
    endcase
  endfunction

  task automatic check_value(input rvc_pkg::rvc_result_t got, input rvc_pkg::rvc_result_t exp,
                             input logic [31:0] src);
    checks_done++;
    if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED at %0t: word %h gave %h ill %b cmp %b, expected %h ill %b cmp %b",
               $time, src, got.instr, got.illegal, got.compressed,
               exp.instr, exp.illegal, exp.compressed);
    end
  endtask

  task automatic protocol_error(input string msg);
    error_count++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  // ----------------------------------------------------------------------
  // credit model and compare
  // ----------------------------------------------------------------------
  always @(posedge clk_i) begin
    if (reset_i) begin
      grant_q = 1'b0;
    end else begin
      if (out_credit_i) begin
        window = 0;
      end
      if (in_valid_i) begin
        window++;
        if (window > MAX_WINDOW) begin
          protocol_error("upstream accepted more words than credits allow");
        end
      end
      if (in_credit_o) begin
        returned++;
        up_credits++;
        if (returned > sent_cnt) begin
          protocol_error("more input credits returned than words sent");
        end
      end
      if (out_valid_o) begin
        if (`RVC_OUT_CREDITS + granted - received <= 0) begin
          protocol_error("output valid without a credit");
        end
        received++;
        if (exp_q.size() == 0) begin
          protocol_error("output valid with no word outstanding");
        end else begin
          check_value(out_result_o, exp_q.pop_front(), src_q.pop_front());
        end
      end
      // a credit returned at this edge is usable from the next cycle on
      if (out_credit_i) begin
        granted++;
      end
      // long stretches without output credits during back-pressure
      if (stall_left > 0) begin
        stall_left--;
        grant_q = 1'b0;
      end else if (stall_en && rand_bits(4) == 0) begin
        stall_left = 16 + int'(rand_bits(5));
        grant_q    = 1'b0;
      end else begin
        grant_q = (received > granted) && rand_bits(1);
      end
    end
  end

  always @(negedge clk_i) begin
    out_credit_i = grant_q;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic send_word(input logic [31:0] w);
    while (up_credits == 0) @(negedge clk_i);
    in_valid_i = 1'b1;
    instr_i    = w;
    up_credits--;
    sent_cnt++;
    exp_q.push_back(ref_expand(w));
    src_q.push_back(w);
    @(negedge clk_i);
    in_valid_i = 1'b0;
  endtask

  task automatic run_test(input string name, input int kind, input int n);
    int errs_before;
    errs_before = error_count;
    stall_en    = (kind == 3);
    for (int i = 0; i < n; i++) begin
      send_word(make_word(kind, i));
    end
    while (received < sent_cnt) @(negedge clk_i);
    stall_en = 1'b0;
    $display("test %s: %0d words, %0d errors", name, n, error_count - errs_before);
  endtask

  initial begin
    clk_i        = 1'b0;
    reset_i      = 1'b1;
    in_valid_i   = 1'b0;
    instr_i      = '0;
    out_credit_i = 1'b0;
    repeat (16) @(negedge clk_i);
    reset_i = 1'b0;
    run_test("uncompressed pass-through", 0, 40);
    run_test("legal expansion", 1, 208);
    run_test("illegal encodings", 2, 84);
    run_test("output back-pressure", 3, 120);
    repeat (4) @(negedge clk_i);
    if (returned != received) protocol_error("input credit pulses do not match outputs");
    $display("checks %0d, errors %0d, sent %0d, received %0d, credits returned %0d",
             checks_done, error_count, sent_cnt, received, returned);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
